//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_motion_tracker
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= TEST PASS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- centroid_accumulator.sv
module centroid_accumulator #(
    parameter motion_pkg::marker_e MARKER = motion_pkg::red_marker
) (
    input  logic                           clk_65mhz,
    input  logic                           reset_8frame_delta_values,
    input  motion_pkg::marker_e            marker,
    input  logic [motion_pkg::X_W-1:0]     marker_x,
    input  logic [motion_pkg::Y_W-1:0]     marker_y,
    input  logic                           frame_end,
    output logic                           div_start,
    output logic [motion_pkg::COUNT_W-1:0] pixel_count,
    output logic [motion_pkg::SUM_W-1:0]   x_sum,
    output logic [motion_pkg::SUM_W-1:0]   y_sum
);

    logic [motion_pkg::COUNT_W-1:0] run_count;
    logic [motion_pkg::SUM_W-1:0]   run_x_sum;
    logic [motion_pkg::SUM_W-1:0]   run_y_sum;
    logic                           hit;

    assign hit = (marker == MARKER);

    always_ff @(posedge clk_65mhz) begin
        if (reset_8frame_delta_values) begin
            run_count   <= '0;
            run_x_sum   <= '0;
            run_y_sum   <= '0;
            pixel_count <= '0;
            x_sum       <= '0;
            y_sum       <= '0;
            div_start   <= 1'b0;
        end else begin
            // empty frame launches nothing, centroid holds
            div_start <= frame_end && (run_count != '0);
            if (frame_end) begin
                pixel_count <= run_count;
                x_sum       <= run_x_sum;
                y_sum       <= run_y_sum;
                run_count   <= '0;
                run_x_sum   <= '0;
                run_y_sum   <= '0;
            end else if (hit) begin
                run_count <= run_count + 1'b1;
                run_x_sum <= run_x_sum + motion_pkg::SUM_W'(marker_x);
                run_y_sum <= run_y_sum + motion_pkg::SUM_W'(marker_y);
            end
        end
    end

    // dividers must never see a zero divisor
    assert property (@(posedge clk_65mhz) disable iff (reset_8frame_delta_values)
        div_start |-> (pixel_count != '0));

endmodule

//--- centroid_divider.sv
module centroid_divider #(
    parameter int DIVIDEND_W = 24,
    parameter int DIVISOR_W  = 16
) (
    input  logic                  clk_65mhz,
    input  logic                  reset_8frame_delta_values,
    input  logic                  start,
    input  logic [DIVIDEND_W-1:0] dividend,
    input  logic [DIVISOR_W-1:0]  divisor,
    output logic                  done,
    output logic [DIVIDEND_W-1:0] quotient
);

    localparam int CNT_W = $clog2(DIVIDEND_W) + 1;

    motion_pkg::div_state_e state;
    logic [CNT_W-1:0]      bit_cnt;
    logic [DIVISOR_W-1:0]  rem;
    logic [DIVIDEND_W-1:0] quo;
    logic [DIVISOR_W-1:0]  den;
    logic [DIVISOR_W-1:0]  src_rem;
    logic [DIVIDEND_W-1:0] src_quo;
    logic [DIVISOR_W-1:0]  src_den;
    logic [DIVISOR_W:0]    trial;
    logic [DIVISOR_W:0]    diff;
    logic [DIVISOR_W-1:0]  next_rem;
    logic [DIVIDEND_W-1:0] next_quo;

    ////////////////////////////////////////////////////////////
    // one restoring step per cycle
    // the first step runs in the start cycle itself
    ////////////////////////////////////////////////////////////

    always_comb begin
        src_rem = start ? '0 : rem;
        src_quo = start ? dividend : quo;
        src_den = start ? divisor : den;
        trial   = {src_rem, src_quo[DIVIDEND_W-1]};
        diff    = trial - {1'b0, src_den};
        if (trial >= {1'b0, src_den}) begin
            next_rem = diff[DIVISOR_W-1:0];
            next_quo = {src_quo[DIVIDEND_W-2:0], 1'b1};
        end else begin
            next_rem = trial[DIVISOR_W-1:0];
            next_quo = {src_quo[DIVIDEND_W-2:0], 1'b0};
        end
    end

    always_ff @(posedge clk_65mhz) begin
        if (reset_8frame_delta_values) begin
            state   <= motion_pkg::idle;
            bit_cnt <= '0;
            done    <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                state   <= motion_pkg::busy;
                bit_cnt <= CNT_W'(1);
            end else if (state == motion_pkg::busy) begin
                bit_cnt <= bit_cnt + 1'b1;
                if (bit_cnt == CNT_W'(DIVIDEND_W - 1)) begin
                    state <= motion_pkg::idle;
                    done  <= 1'b1;
                end
            end
        end
    end

    // dividend bits shift out the top as quotient bits shift in
    always_ff @(posedge clk_65mhz) begin
        if (start || state == motion_pkg::busy) begin
            rem <= next_rem;
            quo <= next_quo;
        end
        if (start) begin
            den <= divisor;
        end
    end

    assign quotient = quo;

    assert property (@(posedge clk_65mhz) disable iff (reset_8frame_delta_values)
        start |-> (state == motion_pkg::idle));

endmodule

//--- gesture_detector.sv
module gesture_detector (
    input  logic                           clk_65mhz,
    input  logic                           reset_8frame_delta_values,
    input  logic                           window_valid,
    input  logic [motion_pkg::TOTAL_W-1:0] dx_total,
    input  logic [motion_pkg::TOTAL_W-1:0] dy_total,
    output logic                           punch,
    output logic                           kick
);

    logic punch_now;
    logic kick_now;

    // magnitudes only, direction does not matter
    assign punch_now = (dx_total > motion_pkg::PUNCH_DX_MIN)
                       && (dy_total < motion_pkg::PUNCH_DY_MAX);
    assign kick_now  = (dy_total > motion_pkg::KICK_DY_MIN)
                       && (dx_total < motion_pkg::KICK_DX_MAX);

    // flags hold until the next window closes
    always_ff @(posedge clk_65mhz) begin
        if (reset_8frame_delta_values) begin
            punch <= 1'b0;
            kick  <= 1'b0;
        end else if (window_valid) begin
            punch <= punch_now;
            kick  <= kick_now;
        end
    end

endmodule

//--- led_pixel_classifier.sv
module led_pixel_classifier (
    input  logic                       clk_65mhz,
    input  logic                       reset_8frame_delta_values,
    input  logic                       pixel_valid,
    input  motion_pkg::pixel_t         pixel,
    input  logic [motion_pkg::X_W-1:0] pixel_x,
    input  logic [motion_pkg::Y_W-1:0] pixel_y,
    output motion_pkg::marker_e        marker,
    output logic [motion_pkg::X_W-1:0] marker_x,
    output logic [motion_pkg::Y_W-1:0] marker_y
);

    logic [3:0] red;
    logic [3:0] green;
    logic [3:0] blue;
    logic       is_red;
    logic       is_white;
    motion_pkg::marker_e label;

    assign red   = pixel[11:8];
    assign green = pixel[7:4];
    assign blue  = pixel[3:0];

    // player 1 led, bright red with almost no green or blue
    assign is_red = (red > motion_pkg::RED_MIN) && (green < motion_pkg::RED_OTHER_MAX)
                    && (blue < motion_pkg::RED_OTHER_MAX);
    // player 2 led, saturated on all channels
    assign is_white = (red > motion_pkg::WHITE_MIN) && (green > motion_pkg::WHITE_MIN)
                      && (blue > motion_pkg::WHITE_MIN);

    always_comb begin
        if (!pixel_valid) begin
            label = motion_pkg::none;
        end else if (is_red) begin
            label = motion_pkg::red_marker;
        end else if (is_white) begin
            label = motion_pkg::ir_marker;
        end else begin
            label = motion_pkg::none;
        end
    end

    always_ff @(posedge clk_65mhz) begin
        if (reset_8frame_delta_values) begin
            marker <= motion_pkg::none;
        end else begin
            marker <= label;
        end
    end

    always_ff @(posedge clk_65mhz) begin
        marker_x <= pixel_x;
        marker_y <= pixel_y;
    end

endmodule

//--- motion_accumulator.sv
module motion_accumulator (
    input  logic                           clk_65mhz,
    input  logic                           reset_8frame_delta_values,
    input  logic                           coord_valid,
    input  logic [motion_pkg::X_W-1:0]     new_x,
    input  logic [motion_pkg::Y_W-1:0]     new_y,
    input  logic                           frame_end,
    output logic                           window_valid,
    output logic [motion_pkg::TOTAL_W-1:0] dx_total,
    output logic                           dx_neg,
    output logic [motion_pkg::TOTAL_W-1:0] dy_total,
    output logic                           dy_neg
);

    localparam int TOTAL_W = motion_pkg::TOTAL_W;
    localparam int TALLY_W = $clog2(motion_pkg::WINDOW_FRAMES);

    motion_pkg::window_state_e state;
    logic [TALLY_W-1:0]         tally;
    logic                       last_frame;
    logic [motion_pkg::X_W-1:0] cur_x;
    logic [motion_pkg::Y_W-1:0] cur_y;
    logic                       pend_valid;
    logic [motion_pkg::X_W-1:0] pend_x;
    logic [motion_pkg::Y_W-1:0] pend_y;
    logic                       apply_valid;
    logic [motion_pkg::X_W-1:0] apply_x;
    logic [motion_pkg::Y_W-1:0] apply_y;
    logic                       x_step_neg;
    logic                       y_step_neg;
    logic [TOTAL_W-1:0]         x_step;
    logic [TOTAL_W-1:0]         y_step;

    // signed-magnitude add, returns {neg, magnitude}
    function automatic logic [TOTAL_W:0] fold(
        input logic [TOTAL_W-1:0] total,
        input logic               total_neg,
        input logic [TOTAL_W-1:0] step,
        input logic               step_neg
    );
        logic [TOTAL_W:0] result;
        if (total_neg == step_neg) begin
            result = {total_neg, total + step};
        end else if (total > step) begin
            result = {total_neg, total - step};
        end else if (step > total) begin
            result = {step_neg, step - total};
        end else begin
            // equal magnitudes cancel to positive zero
            result = '0;
        end
        return result;
    endfunction

    assign last_frame   = (tally == TALLY_W'(motion_pkg::WINDOW_FRAMES - 1));
    assign window_valid = (state == motion_pkg::report);

    // updates held back during report and clear go in afterwards
    always_comb begin
        apply_valid = 1'b0;
        apply_x     = pend_x;
        apply_y     = pend_y;
        if (state == motion_pkg::accumulate) begin
            if (coord_valid) begin
                apply_valid = 1'b1;
                apply_x     = new_x;
                apply_y     = new_y;
            end else if (pend_valid) begin
                apply_valid = 1'b1;
            end
        end
    end

    // movement is new minus current
    assign x_step_neg = (apply_x < cur_x);
    assign y_step_neg = (apply_y < cur_y);
    assign x_step = TOTAL_W'(x_step_neg ? cur_x - apply_x : apply_x - cur_x);
    assign y_step = TOTAL_W'(y_step_neg ? cur_y - apply_y : apply_y - cur_y);

    always_ff @(posedge clk_65mhz) begin
        if (reset_8frame_delta_values) begin
            state      <= motion_pkg::accumulate;
            tally      <= '0;
            cur_x      <= '0;
            cur_y      <= '0;
            pend_valid <= 1'b0;
            dx_total   <= '0;
            dx_neg     <= 1'b0;
            dy_total   <= '0;
            dy_neg     <= 1'b0;
        end else begin
            if (frame_end) begin
                tally <= last_frame ? '0 : tally + 1'b1;
            end
            if (coord_valid && state != motion_pkg::accumulate) begin
                pend_valid <= 1'b1;
            end else if (apply_valid) begin
                pend_valid <= 1'b0;
            end
            case (state)
                motion_pkg::accumulate: begin
                    if (apply_valid) begin
                        {dx_neg, dx_total} <= fold(dx_total, dx_neg, x_step, x_step_neg);
                        {dy_neg, dy_total} <= fold(dy_total, dy_neg, y_step, y_step_neg);
                        cur_x <= apply_x;
                        cur_y <= apply_y;
                    end
                    if (frame_end && last_frame) begin
                        state <= motion_pkg::report;
                    end
                end
                motion_pkg::report: begin
                    state <= motion_pkg::clear;
                end
                default: begin
                    dx_total <= '0;
                    dx_neg   <= 1'b0;
                    dy_total <= '0;
                    dy_neg   <= 1'b0;
                    state    <= motion_pkg::accumulate;
                end
            endcase
        end
    end

    always_ff @(posedge clk_65mhz) begin
        if (coord_valid && state != motion_pkg::accumulate) begin
            pend_x <= new_x;
            pend_y <= new_y;
        end
    end

    assert property (@(posedge clk_65mhz) disable iff (reset_8frame_delta_values)
        window_valid |=> !window_valid);

endmodule

//--- motion_pkg.sv
package motion_pkg;

    // 4 bits each of red, green, blue
    typedef logic [11:0] pixel_t;

    localparam int X_W           = 9;
    localparam int Y_W           = 8;
    localparam int COUNT_W       = 16;
    localparam int SUM_W         = 24;
    localparam int TOTAL_W       = 13;
    localparam int WINDOW_FRAMES = 8;

    // per-channel classifier thresholds, all strict
    localparam logic [3:0] RED_MIN       = 4'd12;
    localparam logic [3:0] RED_OTHER_MAX = 4'd2;
    localparam logic [3:0] WHITE_MIN     = 4'd13;

    // window magnitude thresholds for the gestures
    localparam logic [TOTAL_W-1:0] PUNCH_DX_MIN = TOTAL_W'(64);
    localparam logic [TOTAL_W-1:0] PUNCH_DY_MAX = TOTAL_W'(48);
    localparam logic [TOTAL_W-1:0] KICK_DY_MIN  = TOTAL_W'(64);
    localparam logic [TOTAL_W-1:0] KICK_DX_MAX  = TOTAL_W'(48);

    typedef enum logic [1:0] {
        none,
        red_marker,
        ir_marker
    } marker_e;

    typedef enum logic [1:0] {
        accumulate,
        report,
        clear
    } window_state_e;

    typedef enum logic {
        idle,
        busy
    } div_state_e;

endpackage

//--- motion_tracker_top.sv
module motion_tracker_top (
    input  logic                           clk_65mhz,
    input  logic                           reset_8frame_delta_values,
    input  logic                           pixel_valid,
    input  motion_pkg::pixel_t             pixel,
    input  logic [motion_pkg::X_W-1:0]     pixel_x,
    input  logic [motion_pkg::Y_W-1:0]     pixel_y,
    input  logic                           frame_end,
    output logic                           window_valid,
    output logic [motion_pkg::TOTAL_W-1:0] p1_dx_total,
    output logic                           p1_dx_neg,
    output logic [motion_pkg::TOTAL_W-1:0] p1_dy_total,
    output logic                           p1_dy_neg,
    output logic [motion_pkg::TOTAL_W-1:0] p2_dx_total,
    output logic                           p2_dx_neg,
    output logic [motion_pkg::TOTAL_W-1:0] p2_dy_total,
    output logic                           p2_dy_neg,
    output logic                           p1_punch,
    output logic                           p1_kick,
    output logic                           p2_punch,
    output logic                           p2_kick
);

    localparam int DIVIDEND_W = motion_pkg::SUM_W;
    localparam int DIVISOR_W  = motion_pkg::COUNT_W;

    motion_pkg::marker_e            marker;
    logic [motion_pkg::X_W-1:0]     marker_x;
    logic [motion_pkg::Y_W-1:0]     marker_y;
    logic [1:0]                     div_start;
    logic [DIVISOR_W-1:0]           pixel_count [2];
    logic [DIVIDEND_W-1:0]          x_sum [2];
    logic [DIVIDEND_W-1:0]          y_sum [2];
    logic [1:0]                     x_done;
    logic [DIVIDEND_W-1:0]          x_quo [2];
    logic [DIVIDEND_W-1:0]          y_quo [2];
    logic [1:0]                     win_valid;
    logic [motion_pkg::TOTAL_W-1:0] dx_total [2];
    logic [motion_pkg::TOTAL_W-1:0] dy_total [2];
    logic [1:0]                     dx_neg;
    logic [1:0]                     dy_neg;
    logic [1:0]                     punch;
    logic [1:0]                     kick;

    led_pixel_classifier led_pixel_classifier_inst (
        .clk_65mhz                 (clk_65mhz),
        .reset_8frame_delta_values (reset_8frame_delta_values),
        .pixel_valid               (pixel_valid),
        .pixel                     (pixel),
        .pixel_x                   (pixel_x),
        .pixel_y                   (pixel_y),
        .marker                    (marker),
        .marker_x                  (marker_x),
        .marker_y                  (marker_y)
    );

    ////////////////////////////////////////////////////////////
    // per player chain, index 0 is the red led
    ////////////////////////////////////////////////////////////

    for (genvar p = 0; p < 2; p++) begin : g_player
        centroid_accumulator #(
            .MARKER(p == 0 ? motion_pkg::red_marker : motion_pkg::ir_marker)
        ) centroid_accumulator_inst (
            .clk_65mhz                 (clk_65mhz),
            .reset_8frame_delta_values (reset_8frame_delta_values),
            .marker                    (marker),
            .marker_x                  (marker_x),
            .marker_y                  (marker_y),
            .frame_end                 (frame_end),
            .div_start                 (div_start[p]),
            .pixel_count               (pixel_count[p]),
            .x_sum                     (x_sum[p]),
            .y_sum                     (y_sum[p])
        );

        centroid_divider #(
            .DIVIDEND_W(DIVIDEND_W),
            .DIVISOR_W (DIVISOR_W)
        ) x_divider_inst (
            .clk_65mhz                 (clk_65mhz),
            .reset_8frame_delta_values (reset_8frame_delta_values),
            .start                     (div_start[p]),
            .dividend                  (x_sum[p]),
            .divisor                   (pixel_count[p]),
            .done                      (x_done[p]),
            .quotient                  (x_quo[p])
        );

        // same start and latency as the x divider
        centroid_divider #(
            .DIVIDEND_W(DIVIDEND_W),
            .DIVISOR_W (DIVISOR_W)
        ) y_divider_inst (
            .clk_65mhz                 (clk_65mhz),
            .reset_8frame_delta_values (reset_8frame_delta_values),
            .start                     (div_start[p]),
            .dividend                  (y_sum[p]),
            .divisor                   (pixel_count[p]),
            .done                      (),
            .quotient                  (y_quo[p])
        );

        // centroid always fits the coordinate width
        motion_accumulator motion_accumulator_inst (
            .clk_65mhz                 (clk_65mhz),
            .reset_8frame_delta_values (reset_8frame_delta_values),
            .coord_valid               (x_done[p]),
            .new_x                     (x_quo[p][motion_pkg::X_W-1:0]),
            .new_y                     (y_quo[p][motion_pkg::Y_W-1:0]),
            .frame_end                 (frame_end),
            .window_valid              (win_valid[p]),
            .dx_total                  (dx_total[p]),
            .dx_neg                    (dx_neg[p]),
            .dy_total                  (dy_total[p]),
            .dy_neg                    (dy_neg[p])
        );

        gesture_detector gesture_detector_inst (
            .clk_65mhz                 (clk_65mhz),
            .reset_8frame_delta_values (reset_8frame_delta_values),
            .window_valid              (win_valid[p]),
            .dx_total                  (dx_total[p]),
            .dy_total                  (dy_total[p]),
            .punch                     (punch[p]),
            .kick                      (kick[p])
        );
    end

    assign window_valid = win_valid[0];
    assign p1_dx_total  = dx_total[0];
    assign p1_dx_neg    = dx_neg[0];
    assign p1_dy_total  = dy_total[0];
    assign p1_dy_neg    = dy_neg[0];
    assign p2_dx_total  = dx_total[1];
    assign p2_dx_neg    = dx_neg[1];
    assign p2_dy_total  = dy_total[1];
    assign p2_dy_neg    = dy_neg[1];
    assign p1_punch     = punch[0];
    assign p1_kick      = kick[0];
    assign p2_punch     = punch[1];
    assign p2_kick      = kick[1];

endmodule

//--- tb_motion_tracker.sv
module tb_motion_tracker;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_HALF      = 20;
    localparam int FRAMES        = 40;
    localparam int PIX_PER_FRAME = 14;
    localparam int IDLE_CYCLES   = 50;
    localparam int TW            = motion_pkg::TOTAL_W;
    localparam int EXP_W         = 4 * (TW + 1) + 4;
    localparam logic [31:0] SEED = 32'h1965d83c;

    // scripted window end points per player, windows 0 to 3
    localparam int END_X [2][4] = '{'{200, 300, 220, 215}, '{300, 310, 210, 280}};
    localparam int END_Y [2][4] = '{'{120, 130, 60, 160}, '{100, 200, 190, 180}};

    logic                       clk_65mhz;
    logic                       reset_8frame_delta_values;
    logic                       pixel_valid;
    motion_pkg::pixel_t         pixel;
    logic [motion_pkg::X_W-1:0] pixel_x;
    logic [motion_pkg::Y_W-1:0] pixel_y;
    logic                       frame_end;
    logic                       window_valid;
    logic [TW-1:0]              p1_dx_total;
    logic                       p1_dx_neg;
    logic [TW-1:0]              p1_dy_total;
    logic                       p1_dy_neg;
    logic [TW-1:0]              p2_dx_total;
    logic                       p2_dx_neg;
    logic [TW-1:0]              p2_dy_total;
    logic                       p2_dy_neg;
    logic                       p1_punch;
    logic                       p1_kick;
    logic                       p2_punch;
    logic                       p2_kick;

    int               mismatch_count;
    int               fail_count;
    int               windows_seen;
    logic [31:0]      rng;
    logic [EXP_W-1:0] want_q [$];
    logic [3:0]       held_flags;
    // reference model state, index 0 is player 1
    int cnt [2];
    int sum_x [2];
    int sum_y [2];
    int cur_x [2];
    int cur_y [2];
    int tot_x [2];
    int tot_y [2];

    motion_tracker_top motion_tracker_top_inst (.*);

    initial clk_65mhz = 1'b0;
    always #CLK_HALF clk_65mhz = ~clk_65mhz;

    ////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // 0 none, 1 red marker, 2 white marker
    function automatic int classify(input bit valid, input logic [11:0] c);
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
        r = c[11:8];
        g = c[7:4];
        b = c[3:0];
        if (!valid) return 0;
        if (r > 4'd12 && g < 4'd2
            && b < 4'd2) return 1;
        if (r > 4'd13 && g > 4'd13
            && b > 4'd13) return 2;
        return 0;
    endfunction

    // signed-magnitude form of a net movement, zero is positive
    function automatic logic [TW:0] pack_axis(input int t);
        int mag;
        mag = (t < 0) ? -t : t;
        return {t < 0, TW'(mag)};
    endfunction

    function automatic logic [1:0] gesture(input int tx, input int ty);
        int ax;
        int ay;
        ax = (tx < 0) ? -tx : tx;
        ay = (ty < 0) ? -ty : ty;
        return {ax > 64 && ay < 48, ay > 64 && ax < 48};
    endfunction

    function automatic logic [EXP_W-1:0] window_expect();
        return {pack_axis(tot_x[0]), pack_axis(tot_y[0]), pack_axis(tot_x[1]),
                pack_axis(tot_y[1]), gesture(tot_x[0], tot_y[0]), gesture(tot_x[1], tot_y[1])};
    endfunction

    // straight line between window end points with a back-and-forth wiggle
    function automatic int script_point(input int from, input int to, input int p);
        int wiggle;
        wiggle = (p == 7) ? 0 : ((p % 2 == 1) ? 21 : -9);
        return from + (to - from) * (p + 1) / 8 + wiggle;
    endfunction

    ////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////

    task automatic drive_pixel(input bit valid, input logic [11:0] c, input int x, input int y);
        int kind;
        @(posedge clk_65mhz);
        #2;
        pixel_valid = valid;
        pixel       = c;
        pixel_x     = motion_pkg::X_W'(x);
        pixel_y     = motion_pkg::Y_W'(y);
        kind = classify(valid, c);
        if (kind != 0) begin
            cnt[kind-1]   += 1;
            sum_x[kind-1] += x;
            sum_y[kind-1] += y;
        end
    endtask

    task automatic close_frame(input int f);
        @(posedge clk_65mhz);
        #2;
        pixel_valid = 1'b0;
        @(posedge clk_65mhz);
        #2;
        frame_end = 1'b1;
        @(posedge clk_65mhz);
        #2;
        frame_end = 1'b0;
        // window closes before this frame's centroid lands
        if (f % motion_pkg::WINDOW_FRAMES == motion_pkg::WINDOW_FRAMES - 1) begin
            want_q.push_back(window_expect());
            tot_x = '{0, 0};
            tot_y = '{0, 0};
        end
        for (int pl = 0; pl < 2; pl++) begin
            if (cnt[pl] != 0) begin
                tot_x[pl] += sum_x[pl] / cnt[pl] - cur_x[pl];
                tot_y[pl] += sum_y[pl] / cnt[pl] - cur_y[pl];
                cur_x[pl]  = sum_x[pl] / cnt[pl];
                cur_y[pl]  = sum_y[pl] / cnt[pl];
            end
            cnt[pl]   = 0;
            sum_x[pl] = 0;
            sum_y[pl] = 0;
        end
        repeat (IDLE_CYCLES) @(posedge clk_65mhz);
    endtask

    task automatic build_frame(input int f);
        int  k;
        int  p;
        int  px [2];
        int  py [2];
        bit  drop [2];
        k = (f + 1) / 8;
        p = (f + 1) % 8;
        for (int pl = 0; pl < 2; pl++) begin
            if (k >= 4) begin
                rng = xorshift(rng);
                px[pl] = 20 + int'(rng % 32'd460);
                rng = xorshift(rng);
                py[pl] = 20 + int'(rng % 32'd210);
            end else begin
                px[pl] = script_point(k == 0 ? 0 : END_X[pl][k-1], END_X[pl][k], p);
                py[pl] = script_point(k == 0 ? 0 : END_Y[pl][k-1], END_Y[pl][k], p);
            end
        end
        // frames without one player's led, at the end of a window
        drop[0] = (k == 2 && p == 7);
        drop[1] = (k == 3 && (p == 6 || p == 7));
        drive_pixel(1'b1, 12'h000, 3 * f, 7);
        drive_pixel(1'b1, 12'h48C, 100 + f, 40);
        if (!drop[0]) begin
            drive_pixel(1'b1, 12'hF00, px[0], py[0]);
            drive_pixel(1'b1, 12'hD11, px[0] + 1, py[0]);
            drive_pixel(1'b1, 12'hE01, px[0] + 1, py[0] + 1);
        end
        // near misses far away so a wrong count moves the centroid
        drive_pixel(1'b1, 12'hC00, 500, 250);
        drive_pixel(1'b1, 12'hD20, 500, 250);
        drive_pixel(1'b1, 12'hD02, 500, 250);
        drive_pixel(1'b1, 12'hDDD, 500, 250);
        drive_pixel(1'b1, 12'hEDE, 500, 250);
        drive_pixel(1'b0, 12'hF00, 500, 250);
        if (!drop[1]) begin
            drive_pixel(1'b1, 12'hFFF, px[1], py[1]);
            drive_pixel(1'b1, 12'hEEE, px[1] + 1, py[1]);
            drive_pixel(1'b1, 12'hFEF, px[1] + 1, py[1] + 1);
        end
        close_frame(f);
    endtask

    task automatic print_error_counts();
        $display("errors: %0d mismatches, %0d other failures", mismatch_count, fail_count);
    endtask

    ////////////////////////////////////////////////////////////
    // comparison
    ////////////////////////////////////////////////////////////

    always @(negedge clk_65mhz) begin
        logic [EXP_W-1:0] want;
        logic [3:0]       got_flags;
        got_flags = {p1_punch, p1_kick, p2_punch, p2_kick};
        if (!reset_8frame_delta_values) begin
            assert (got_flags == held_flags) else begin
                mismatch_count++;
                $display("MISMATCH at %0t: gesture flags %b, expected %b",
                         $time, got_flags, held_flags);
            end
            if (window_valid) begin
                if (want_q.size() == 0) begin
                    fail_count++;
                    $display("window_valid pulsed when no window was due at %0t", $time);
                end else begin
                    want = want_q.pop_front();
                    windows_seen++;
                    assert ({p1_dx_neg, p1_dx_total, p1_dy_neg, p1_dy_total, p2_dx_neg,
                             p2_dx_total, p2_dy_neg, p2_dy_total} == want[EXP_W-1:4]) else begin
                        mismatch_count++;
                        $display("MISMATCH at %0t: window %0d totals %h, expected %h",
                                 $time, windows_seen, {p1_dx_neg, p1_dx_total, p1_dy_neg,
                                 p1_dy_total, p2_dx_neg, p2_dx_total, p2_dy_neg,
                                 p2_dy_total}, want[EXP_W-1:4]);
                    end
                    held_flags = want[3:0];
                end
            end
        end
    end

    initial begin
        repeat (FRAMES * (PIX_PER_FRAME + 60) + 200) @(posedge clk_65mhz);
        $display("timeout: the run did not finish in the expected number of cycles");
        print_error_counts();
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        mismatch_count            = 0;
        fail_count                = 0;
        windows_seen              = 0;
        held_flags                = '0;
        rng                       = SEED;
        cnt                       = '{0, 0};
        sum_x                     = '{0, 0};
        sum_y                     = '{0, 0};
        cur_x                     = '{0, 0};
        cur_y                     = '{0, 0};
        tot_x                     = '{0, 0};
        tot_y                     = '{0, 0};
        reset_8frame_delta_values = 1'b1;
        pixel_valid               = 1'b0;
        pixel                     = '0;
        pixel_x                   = '0;
        pixel_y                   = '0;
        frame_end                 = 1'b0;
        repeat (5) @(posedge clk_65mhz);
        #2;
        reset_8frame_delta_values = 1'b0;
        @(negedge clk_65mhz);
        assert ({window_valid, p1_dx_total, p1_dx_neg, p1_dy_total, p1_dy_neg, p2_dx_total,
                 p2_dx_neg, p2_dy_total, p2_dy_neg} == '0) else begin
            mismatch_count++;
            $display("MISMATCH at %0t: outputs not zero after reset", $time);
        end
        for (int f = 0; f < FRAMES; f++) begin
            build_frame(f);
        end
        repeat (5) @(posedge clk_65mhz);
        assert (windows_seen == FRAMES / motion_pkg::WINDOW_FRAMES && want_q.size() == 0)
        else begin
            fail_count++;
            $display("saw %0d windows but expected %0d", windows_seen,
                     FRAMES / motion_pkg::WINDOW_FRAMES);
        end
        print_error_counts();
        if (mismatch_count == 0 && fail_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

//--- verilog.f
motion_pkg.sv
led_pixel_classifier.sv
centroid_accumulator.sv
centroid_divider.sv
motion_accumulator.sv
gesture_detector.sv
motion_tracker_top.sv
tb_motion_tracker.sv
